// ==== design/kg_regfile_pkg.sv ====
package kg_regfile_pkg;

    // ------------------------------------------------------------
    // Bus and register geometry
    // ------------------------------------------------------------
    localparam int data_width  = 32;
    localparam int strb_width  = data_width / 8;
    localparam int addr_width  = 16;
    localparam int reg_count   = 32;

    // Register index sits in address bits 6 down to 2
    localparam int addr_lsb    = 2;
    localparam int index_width = 5;

    // ------------------------------------------------------------
    // AXI4-Lite channel payloads
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    typedef struct packed {
        logic [addr_width-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        axil_resp_e            resp;
    } axil_r_t;

    // ------------------------------------------------------------
    // Internal bank request and exported command
    // ------------------------------------------------------------
    typedef struct packed {
        logic [index_width-1:0] index;
        logic [data_width-1:0]  data;
        logic [strb_width-1:0]  strb;
    } bank_wr_t;

    // Registers 0 to 3, register 0 in the top word
    typedef struct packed {
        logic [data_width-1:0] address_valid;
        logic [data_width-1:0] address;
        logic [data_width-1:0] data_valid;
        logic [data_width-1:0] data;
    } kg_cmd_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ACCEPT,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACCEPT,
        RD_DATA
    } rd_state_e;

endpackage

// ==== design/axil_write_ctrl.sv ====
module axil_write_ctrl (
    input  logic                       clk,
    input  logic                       S_AXI_ARESETN,
    input  kg_regfile_pkg::axil_aw_t   aw,
    input  logic                       awvalid,
    output logic                       awready,
    input  kg_regfile_pkg::axil_w_t    w,
    input  logic                       wvalid,
    output logic                       wready,
    output kg_regfile_pkg::axil_resp_e bresp,
    output logic                       bvalid,
    input  logic                       bready,
    output logic                       wr_en,
    output kg_regfile_pkg::bank_wr_t   wr_req
);

    kg_regfile_pkg::wr_state_e state;
    kg_regfile_pkg::wr_state_e state_next;
    logic                      both_valid;

    // Address and data are taken together, never one without the other
    assign both_valid = awvalid && wvalid;

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            kg_regfile_pkg::WR_IDLE:
            begin
                if (both_valid)
                    state_next = kg_regfile_pkg::WR_ACCEPT;
            end
            // Master holds both valids, so the transfer always completes here
            kg_regfile_pkg::WR_ACCEPT: state_next = kg_regfile_pkg::WR_RESP;
            kg_regfile_pkg::WR_RESP:
            begin
                if (bready)
                    state_next = kg_regfile_pkg::WR_IDLE;
            end
            default: state_next = kg_regfile_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!S_AXI_ARESETN)
            state <= kg_regfile_pkg::WR_IDLE;
        else
            state <= state_next;
    end

    // Capture the request on the way out of idle
    always_ff @(posedge clk)
    begin
        if (state == kg_regfile_pkg::WR_IDLE && both_valid)
        begin
            wr_req.index <= aw.addr[kg_regfile_pkg::addr_lsb +: kg_regfile_pkg::index_width];
            wr_req.data  <= w.data;
            wr_req.strb  <= w.strb;
        end
    end

    // ------------------------------------------------------------
    // Handshake outputs
    // ------------------------------------------------------------
    assign awready = (state == kg_regfile_pkg::WR_ACCEPT);
    assign wready  = (state == kg_regfile_pkg::WR_ACCEPT);
    assign wr_en   = (state == kg_regfile_pkg::WR_ACCEPT);
    assign bvalid  = (state == kg_regfile_pkg::WR_RESP);
    assign bresp   = kg_regfile_pkg::OKAY;

endmodule

// ==== design/axil_read_ctrl.sv ====
module axil_read_ctrl (
    input  logic                                      clk,
    input  logic                                      S_AXI_ARESETN,
    input  kg_regfile_pkg::axil_ar_t                  ar,
    input  logic                                      arvalid,
    output logic                                      arready,
    output kg_regfile_pkg::axil_r_t                   r,
    output logic                                      rvalid,
    input  logic                                      rready,
    output logic                                      rd_en,
    output logic [kg_regfile_pkg::index_width-1:0]    rd_index,
    input  logic [kg_regfile_pkg::data_width-1:0]     rd_data
);

    kg_regfile_pkg::rd_state_e state;
    kg_regfile_pkg::rd_state_e state_next;

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            kg_regfile_pkg::RD_IDLE:
            begin
                if (arvalid)
                    state_next = kg_regfile_pkg::RD_ACCEPT;
            end
            kg_regfile_pkg::RD_ACCEPT: state_next = kg_regfile_pkg::RD_DATA;
            // No new address is taken until the data has gone out
            kg_regfile_pkg::RD_DATA:
            begin
                if (rready)
                    state_next = kg_regfile_pkg::RD_IDLE;
            end
            default: state_next = kg_regfile_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!S_AXI_ARESETN)
            state <= kg_regfile_pkg::RD_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (state == kg_regfile_pkg::RD_IDLE && arvalid)
            rd_index <= ar.addr[kg_regfile_pkg::addr_lsb +: kg_regfile_pkg::index_width];
    end

    // ------------------------------------------------------------
    // Handshake and read data
    // ------------------------------------------------------------
    assign arready = (state == kg_regfile_pkg::RD_ACCEPT);
    assign rd_en   = (state == kg_regfile_pkg::RD_ACCEPT);
    assign rvalid  = (state == kg_regfile_pkg::RD_DATA);

    // Bank holds rd_data between reads, so r is stable while rvalid waits
    assign r.data  = rd_data;
    assign r.resp  = kg_regfile_pkg::OKAY;

endmodule

// ==== design/kg_reg_bank.sv ====
module kg_reg_bank (
    input  logic                                      clk,
    input  logic                                      S_AXI_ARESETN,
    input  logic                                      wr_en,
    input  kg_regfile_pkg::bank_wr_t                  wr_req,
    input  logic                                      rd_en,
    input  logic [kg_regfile_pkg::index_width-1:0]    rd_index,
    output logic [kg_regfile_pkg::data_width-1:0]     rd_data,
    output kg_regfile_pkg::kg_cmd_t                   kg_cmd
);

    logic [kg_regfile_pkg::data_width-1:0] regs [kg_regfile_pkg::reg_count];

    // ------------------------------------------------------------
    // Register array with byte-strobe writes
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!S_AXI_ARESETN)
        begin
            for (int i = 0; i < kg_regfile_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            // Bytes without a strobe keep their old value
            for (int b = 0; b < kg_regfile_pkg::strb_width; b++)
            begin
                if (wr_req.strb[b])
                    regs[wr_req.index][b*8 +: 8] <= wr_req.data[b*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------
    // Registered read port
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!S_AXI_ARESETN)
            rd_data <= '0;
        else if (rd_en)
            rd_data <= regs[rd_index];
    end

    // Command export follows the first four registers
    assign kg_cmd.address_valid = regs[0];
    assign kg_cmd.address       = regs[1];
    assign kg_cmd.data_valid    = regs[2];
    assign kg_cmd.data          = regs[3];

endmodule

// ==== design/kg_regfile_top.sv ====
module kg_regfile_top (
    input  logic                       clk,
    input  logic                       S_AXI_ARESETN,
    input  kg_regfile_pkg::axil_aw_t   aw,
    input  logic                       awvalid,
    output logic                       awready,
    input  kg_regfile_pkg::axil_w_t    w,
    input  logic                       wvalid,
    output logic                       wready,
    output kg_regfile_pkg::axil_resp_e bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  kg_regfile_pkg::axil_ar_t   ar,
    input  logic                       arvalid,
    output logic                       arready,
    output kg_regfile_pkg::axil_r_t    r,
    output logic                       rvalid,
    input  logic                       rready,
    output kg_regfile_pkg::kg_cmd_t    kg_cmd
);

    // Between the controllers and the bank
    logic                                   wr_en;
    kg_regfile_pkg::bank_wr_t               wr_req;
    logic                                   rd_en;
    logic [kg_regfile_pkg::index_width-1:0] rd_index;
    logic [kg_regfile_pkg::data_width-1:0]  rd_data;

    axil_write_ctrl u_axil_write_ctrl (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .wr_en         (wr_en),
        .wr_req        (wr_req)
    );

    axil_read_ctrl u_axil_read_ctrl (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .rd_data       (rd_data)
    );

    kg_reg_bank u_kg_reg_bank (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_en         (wr_en),
        .wr_req        (wr_req),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .rd_data       (rd_data),
        .kg_cmd        (kg_cmd)
    );

endmodule

// ==== tests/tb_kg_axil_tasks.svh ====
`ifndef TB_KG_AXIL_TASKS_SVH
`define TB_KG_AXIL_TASKS_SVH

// ------------------------------------------------------------
// AXI4-Lite master tasks, called on a falling clock edge
// ------------------------------------------------------------

// Present one write and wait until its response is valid
task automatic write_issue(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    aw.addr = addr;
    w.data  = data;
    w.strb  = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do
        @(negedge clk);
    while (!(awready && wready));
    // Address and data transfer on the edge after both readies are seen
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
        @(negedge clk);
endtask

// Take the write response after 0 to max_delay cycles of bready back-pressure
task automatic write_resp(input int max_delay);
    int delay;
    delay = $urandom_range(max_delay, 0);
    repeat (delay) @(negedge clk);
    assert (bresp == kg_regfile_pkg::OKAY)
    else abort_run($sformatf("Mismatch bresp: got %h expected %h", bresp, kg_regfile_pkg::OKAY));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
endtask

// One write, then 0 to 3 cycles of bready back-pressure
task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
    write_issue(addr, data, strb);
    write_resp(3);
endtask

// Present one read and wait until its data is valid
task automatic read_issue(input logic [15:0] addr);
    ar.addr = addr;
    arvalid = 1'b1;
    do
        @(negedge clk);
    while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid)
        @(negedge clk);
endtask

// Take the read data after 0 to max_delay cycles of rready back-pressure
task automatic read_resp(input int max_delay, output logic [31:0] data);
    int delay;
    delay = $urandom_range(max_delay, 0);
    repeat (delay) @(negedge clk);
    data = r.data;
    assert (r.resp == kg_regfile_pkg::OKAY)
    else abort_run($sformatf("Mismatch r.resp: got %h expected %h", r.resp, kg_regfile_pkg::OKAY));
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
endtask

// One read, then 0 to 3 cycles of rready back-pressure
task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
    read_issue(addr);
    read_resp(3, data);
endtask

`endif

// ==== tests/tb_kg_regfile.sv ====
module tb_kg_regfile;

    // Transactions issued by the sequence below, for the watchdog
    localparam int txn_count = 168;

    logic                       clk;
    logic                       S_AXI_ARESETN;
    kg_regfile_pkg::axil_aw_t   aw;
    logic                       awvalid;
    logic                       awready;
    kg_regfile_pkg::axil_w_t    w;
    logic                       wvalid;
    logic                       wready;
    kg_regfile_pkg::axil_resp_e bresp;
    logic                       bvalid;
    logic                       bready;
    kg_regfile_pkg::axil_ar_t   ar;
    logic                       arvalid;
    logic                       arready;
    kg_regfile_pkg::axil_r_t    r;
    logic                       rvalid;
    logic                       rready;
    kg_regfile_pkg::kg_cmd_t    kg_cmd;

    // Reference copy of the register array
    logic [31:0] ref_regs [32];

    kg_regfile_top u_kg_regfile_top (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .kg_cmd        (kg_cmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    `include "tb_kg_axil_tasks.svh"

    initial
    begin
        #((txn_count * 12 + 100) * 20);
        abort_run("Timeout: a handshake never completed");
    end

    // ------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        bvalid && !bready |=> bvalid)
    else abort_run("bvalid dropped before bready was seen");

    assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid && $stable(r))
    else abort_run("rvalid or r changed while waiting for rready");

    assert property (@(posedge clk) disable iff (!S_AXI_ARESETN) bvalid |-> !awready)
    else abort_run("awready raised while a write response was pending");

    assert property (@(posedge clk) disable iff (!S_AXI_ARESETN) rvalid |-> !arready)
    else abort_run("arready raised while read data was pending");

    // Timing from an idle channel only
    assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        $rose(awvalid && wvalid) && !bvalid |-> ##2 $rose(bvalid))
    else abort_run("bvalid did not rise two cycles after awvalid and wvalid");

    assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        $rose(arvalid) && !rvalid |-> ##2 $rose(rvalid))
    else abort_run("rvalid did not rise two cycles after arvalid");

    // ------------------------------------------------------------
    // Reference model and checking tasks
    // ------------------------------------------------------------
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                word[b*8 +: 8] = data[b*8 +: 8];
        end
        return word;
    endfunction

    task automatic check_cmd;
        assert (kg_cmd == {ref_regs[0], ref_regs[1], ref_regs[2], ref_regs[3]})
        else abort_run($sformatf("Mismatch kg_cmd: got %h expected %h", kg_cmd,
                                 {ref_regs[0], ref_regs[1], ref_regs[2], ref_regs[3]}));
    endtask

    // Write, track it in the reference array, check the command export
    task automatic write_and_check(input logic [15:0] addr, input logic [31:0] data,
                                   input logic [3:0] strb);
        write_reg(addr, data, strb);
        ref_regs[addr[6:2]] = merge_bytes(ref_regs[addr[6:2]], data, strb);
        check_cmd();
    endtask

    task automatic check_read(input logic [15:0] addr);
        logic [31:0] got;
        read_reg(addr, got);
        assert (got == ref_regs[addr[6:2]])
        else abort_run($sformatf("Mismatch r.data at %h: got %h expected %h", addr, got,
                                 ref_regs[addr[6:2]]));
    endtask

    // Second write is presented while the first response is held back
    task automatic overlap_writes(input logic [15:0] addr_a, input logic [15:0] addr_b,
                                  input logic [31:0] data_a, input logic [31:0] data_b);
        write_issue(addr_a, data_a, 4'hf);
        aw.addr = addr_b;
        w.data  = data_b;
        w.strb  = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        repeat (2) @(negedge clk);
        write_resp(0);
        ref_regs[addr_a[6:2]] = data_a;
        write_and_check(addr_b, data_b, 4'hf);
    endtask

    // Second read is presented while the first read data is held back
    task automatic overlap_reads(input logic [15:0] addr_a, input logic [15:0] addr_b);
        logic [31:0] got;
        read_issue(addr_a);
        ar.addr = addr_b;
        arvalid = 1'b1;
        repeat (2) @(negedge clk);
        read_resp(0, got);
        assert (got == ref_regs[addr_a[6:2]])
        else abort_run($sformatf("Mismatch r.data at %h: got %h expected %h", addr_a, got,
                                 ref_regs[addr_a[6:2]]));
        check_read(addr_b);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        logic [4:0]  idx;
        logic [15:0] alias_addr;
        void'($urandom(32'hc7e004fa));
        S_AXI_ARESETN = 1'b0;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        S_AXI_ARESETN = 1'b1;

        // Reset state
        assert (!awready && !wready && !bvalid && !arready && !rvalid)
        else abort_run("Handshake outputs are not low after reset");
        check_cmd();
        for (int i = 0; i < 32; i++)
            check_read(16'(i * 4));

        // Full-strobe writes to every register
        for (int i = 0; i < 32; i++)
            write_and_check(16'(i * 4), $urandom(), 4'hf);
        for (int i = 0; i < 32; i++)
            check_read(16'(i * 4));

        // Partial strobes merge into the old value
        repeat (16)
        begin
            idx = 5'($urandom());
            write_and_check({9'd0, idx, 2'b00}, $urandom(), 4'($urandom_range(15, 0)));
            check_read({9'd0, idx, 2'b00});
        end

        // Command registers, then others that must not touch kg_cmd
        for (int i = 0; i < 4; i++)
            write_and_check(16'(i * 4), $urandom(), 4'hf);
        for (int i = 4; i < 8; i++)
            write_and_check(16'(i * 4), $urandom(), 4'hf);

        // New requests wait while a response is held back
        for (int i = 8; i < 12; i++)
        begin
            overlap_writes(16'(i * 4), 16'(i * 4 + 64), $urandom(), $urandom());
            overlap_reads(16'(i * 4), 16'(i * 4 + 64));
        end

        // Address aliases outside bits 6 down to 2
        repeat (8)
        begin
            idx = 5'($urandom());
            alias_addr = {9'($urandom()), idx, 2'($urandom())};
            write_and_check(alias_addr, $urandom(), 4'hf);
            check_read({9'($urandom()), idx, 2'($urandom())});
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+tests
design/kg_regfile_pkg.sv
design/axil_write_ctrl.sv
design/axil_read_ctrl.sv
design/kg_reg_bank.sv
design/kg_regfile_top.sv
tests/tb_kg_regfile.sv

// ==== Bender.yml ====
package:
  name: kg_regfile

sources:
  - design/kg_regfile_pkg.sv
  - design/axil_write_ctrl.sv
  - design/axil_read_ctrl.sv
  - design/kg_reg_bank.sv
  - design/kg_regfile_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_kg_regfile.sv
